//--- Bender.yml
package:
  name: tx_clk_gen

sources:
  # Design sources in compile order
  - files:
      - logic/clk_cfg_pkg.sv
      - logic/clk_state_pkg.sv
      - logic/clock_divider.sv
      - logic/clock_divider_quad.sv
      - logic/tx_clk_ctrl.sv
      - logic/tx_clk_gen.sv

  # Testbench and bound properties
  - target: test
    files:
      - dv/tx_clk_gen_props.sv
      - dv/tx_clk_gen_tb.sv

//--- dv/tx_clk_gen_props.sv
// ##############################
// Transmit clock generator properties
// Reset, gating, restart and phase ordering rules
// ##############################
`default_nettype none

module tx_clk_gen_props
  import clk_cfg_pkg::*;
(
  input logic      clkin,                       // Reference clock
  input logic      reset,                       // Async reset
  input logic      out_en,                      // Output gate
  input logic      restart,                     // Divider restart hold
  input div_code_t div_code,                    // Active divide code
  input logic      clk_main,                    // Divided link clock
  input logic      clk_quad,                    // Quarter-phase copy
  input logic      lock,                        // Lock status
  input logic      cfg_err                      // Bad code pulse
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;                           // Read by the testbench top

  // Everything quiet while reset is held
  a_reset_quiet: assert property (@(posedge clkin)
    reset |-> (!lock && !cfg_err && !clk_main && !clk_quad))
    else begin fail_count++; $error("outputs active during reset"); end

  a_gate_off: assert property (@(posedge clkin) disable iff (reset)
    !out_en |-> (!clk_main && !clk_quad))       // Gate closed, outputs low
    else begin fail_count++; $error("output toggles while disabled"); end

  a_restart_low: assert property (@(posedge clkin) disable iff (reset)
    restart |-> (!clk_main && !clk_quad && !lock))
    else begin fail_count++; $error("output or lock high during restart"); end

  a_quad_order: assert property (@(posedge clkin) disable iff (reset)
    $rose(clk_quad) |-> clk_main)               // Quad lags main by a quarter
    else begin fail_count++; $error("clk_quad rose while clk_main low"); end

  a_quad_low_code: assert property (@(posedge clkin) disable iff (reset)
    (div_code < DIV4) |-> !clk_quad)            // No quarter phase below divide by 4
    else begin fail_count++; $error("clk_quad active for code below 2"); end

  a_cfg_err_pulse: assert property (@(posedge clkin) disable iff (reset)
    cfg_err |=> !cfg_err)                       // Single-cycle pulse
    else begin fail_count++; $error("cfg_err held longer than one cycle"); end

endmodule

bind tx_clk_gen tx_clk_gen_props props0 (
  .clkin   (clkin),
  .reset   (reset),
  .out_en  (out_en),
  .restart (restart),
  .div_code(div_code),
  .clk_main(clk_main),
  .clk_quad(clk_quad),
  .lock    (lock),
  .cfg_err (cfg_err)
);

`default_nettype wire

//--- dv/tx_clk_gen_tb.sv
// ##############################
// Transmit clock generator testbench
// Commands, period and quarter-phase measurement
// ##############################
`default_nettype none

module tx_clk_gen_tb
  import clk_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOCK_TMO = 400;                // Cycles allowed for lock
  localparam int EDGE_TMO = 600;                // Cycles allowed for a clock rise

  logic       clkin;
  logic       reset;
  logic       cmd_valid;
  clk_op_t    cmd_op;
  logic [3:0] cmd_code;
  logic       clk_main;
  logic       clk_quad;
  logic       lock;
  logic       cfg_err;

  int     errors;                               // Testbench check failures
  integer seed;                                 // $random state
  int     cur_code;                             // Last legal code sent
  int     code;
  int     bad;
  int     skip;                                 // Cycles to the gate-opening rise

  tx_clk_gen #(
    .RESTART_CYCLES(2)
  ) dut0 (
    .clkin    (clkin),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_code (cmd_code),
    .clk_main (clk_main),
    .clk_quad (clk_quad),
    .lock     (lock),
    .cfg_err  (cfg_err)
  );

  always #50 clkin = ~clkin;                    // 100 ns period

  // ##############################
  // Helpers
  // ##############################

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  function automatic logic probe(input bit quad);
    return quad ? clk_quad : clk_main;          // Clock under measurement
  endfunction

  task automatic send_cmd(input clk_op_t op, input logic [3:0] code_in);
    @(posedge clkin);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_code  <= code_in;
    @(posedge clkin);                           // DUT samples here
    cmd_valid <= 1'b0;
    cmd_op    <= OP_NOP;
  endtask

  task automatic wait_lock(input string name);
    int n;
    n = 0;
    @(negedge clkin);
    while (!lock && n < LOCK_TMO) begin
      @(negedge clkin);
      n++;
    end
    if (!lock) begin
      errors++;
      $display("%s: lock did not rise within %0d cycles", name, LOCK_TMO);
    end
  endtask

  // Falling-edge samples until the chosen clock rises, -1 on timeout
  task automatic cycles_to_rise(input string name, input bit quad, output int n);
    logic prev;
    n = 0;
    do begin
      prev = probe(quad);
      @(negedge clkin);
      n++;
    end while (!(probe(quad) && !prev) && n < EDGE_TMO);
    if (!(probe(quad) && !prev)) begin
      errors++;
      $display("%s: no %s rise within %0d cycles", name,
               quad ? "clk_quad" : "clk_main", EDGE_TMO);
      n = -1;
    end
  endtask

  task automatic check_period(input string name, input int exp);
    int n;
    cycles_to_rise(name, 1'b0, n);              // Align to a main rise
    if (n >= 0) begin
      cycles_to_rise(name, 1'b0, n);
      if (n >= 0) check_value(name, exp, n);
    end
  endtask

  task automatic check_quad(input string name, input int exp);
    int n;
    cycles_to_rise(name, 1'b0, n);
    if (n >= 0) begin
      cycles_to_rise(name, 1'b1, n);            // Main rise to quad rise
      if (n >= 0) check_value(name, exp, n);
    end
  endtask

  task automatic run_code(input int c);
    send_cmd(OP_SET_DIV, 4'(c));
    cur_code = c;
    wait_lock($sformatf("lock code %0d", c));
    check_period($sformatf("period code %0d", c), 1 << c);
    if (c >= 2) check_quad($sformatf("quad offset code %0d", c), (1 << c) / 4);
  endtask

  // ##############################
  // Stimulus
  // ##############################

  initial begin
    clkin     = 1'b0;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_code  = 4'd0;
    errors    = 0;
    cur_code  = 0;
    seed      = 32'h251d2e80;
    repeat (16) @(posedge clkin);
    reset <= 1'b0;

    repeat (20) begin                           // Quiet before the first enable
      @(negedge clkin);
      check_value("idle lock", 0, lock);
      check_value("idle clk_main", 0, clk_main);
      check_value("idle clk_quad", 0, clk_quad);
      check_value("idle cfg_err", 0, cfg_err);
    end

    send_cmd(OP_ENABLE, 4'd0);
    wait_lock("lock after enable");
    for (code = 1; code <= 7; code++) begin
      run_code(code);
    end
    repeat (3) run_code(1 + ($unsigned($random(seed)) % 7));

    bad = 8 + ($unsigned($random(seed)) % 8);   // Illegal code
    send_cmd(OP_SET_DIV, 4'(bad));
    @(negedge clkin);
    check_value("cfg_err pulse", 1, cfg_err);
    @(negedge clkin);
    check_value("cfg_err clear", 0, cfg_err);
    check_value("lock after bad code", 1, lock);
    check_period("period after bad code", 1 << cur_code);

    send_cmd(OP_DISABLE, 4'd0);
    repeat (2 << cur_code) begin                // Two full periods gated
      @(negedge clkin);
      check_value("disabled clk_main", 0, clk_main);
      check_value("disabled clk_quad", 0, clk_quad);
    end
    check_value("lock while disabled", 1, lock);
    send_cmd(OP_ENABLE, 4'd0);
    cycles_to_rise("rise after enable", 1'b0, skip); // Gate may open mid period
    check_period("period after enable", 1 << cur_code);

    send_cmd(OP_SET_DIV, 4'd0);                 // Bypass
    wait_lock("lock code 0");
    repeat (8) begin
      @(posedge clkin);
      #10;
      check_value("bypass clk_main high", 1, clk_main);
      check_value("bypass clk_quad", 0, clk_quad);
      @(negedge clkin);
      #10;
      check_value("bypass clk_main low", 0, clk_main);
    end

    $display("Closing: %0d check errors, %0d assertion failures",
             errors, dut0.props0.fail_count);
    if (errors == 0 && dut0.props0.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/clk_cfg_pkg.sv
// ##############################
// Link clock configuration types
// Divide codes, commands and the divider width
// ##############################
`default_nettype none

package clk_cfg_pkg;

  localparam int CNT_W = 8;                     // Counter width, covers divide by 128

  // Divide factor is 2**code
  typedef enum logic [3:0] {
    DIV1   = 4'd0,                              // Bypass
    DIV2   = 4'd1,
    DIV4   = 4'd2,                              // Lowest code with a quarter phase
    DIV8   = 4'd3,
    DIV16  = 4'd4,
    DIV32  = 4'd5,
    DIV64  = 4'd6,
    DIV128 = 4'd7                               // Largest legal code
  } div_code_t;

  typedef enum logic [1:0] {
    OP_NOP     = 2'd0,                          // No action
    OP_SET_DIV = 2'd1,                          // Load code and restart
    OP_ENABLE  = 2'd2,                          // Open output gates
    OP_DISABLE = 2'd3                           // Close output gates
  } clk_op_t;

  // One-hot period value for a divide code
  function automatic logic [CNT_W-1:0] period_of(input div_code_t code);
    logic [CNT_W-1:0] per;
    if (code <= DIV128) begin
      per = CNT_W'(1) << code;                  // 2**code
    end else begin
      per = '0;                                 // Never matches
    end
    return per;
  endfunction

endpackage

`default_nettype wire

//--- logic/clk_state_pkg.sv
// ##############################
// Controller state encoding
// ##############################
`default_nettype none

package clk_state_pkg;

  // Restart sequencer states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,                          // Out of reset, waiting for enable
    ST_RESTART = 2'd1,                          // Dividers held at count one
    ST_RUN     = 2'd2                           // Dividers free running
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/clock_divider.sv
// ##############################
// Main link clock divider
// Power-of-two divide with a bypass and a wrap pulse
// ##############################
`default_nettype none

module clock_divider
  import clk_cfg_pkg::*;
(
  input  logic      clkin,                      // Reference clock
  input  logic      reset,                      // Async reset
  input  logic      restart,                    // Hold counter at one
  input  logic      out_en,                     // Output gate
  input  div_code_t div_code,                   // Divide code
  output logic      clk_out,                    // Divided clock
  output logic      wrap                        // Full period match
);

  logic [CNT_W-1:0] period;                     // One-hot period
  logic [CNT_W-1:0] half;                       // Half period
  logic [CNT_W-1:0] counter;                    // Runs 1 to period
  logic             rise_match;                 // Counter at full period
  logic             fall_match;                 // Counter at half period
  logic             clk_reg;                    // Registered divided clock
  logic             bypass;                     // Divide by one

  // ##############################
  // Period decode
  // ##############################

  assign period     = period_of(div_code);
  assign half       = period >> 1;              // Zero for bypass, never matches
  assign rise_match = (counter == period);
  assign fall_match = (counter == half);
  assign bypass     = (div_code == DIV1);

  // ##############################
  // Counter and clock register
  // ##############################

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      counter <= CNT_W'(1);
    end else if (restart || rise_match) begin
      counter <= CNT_W'(1);                     // Self reload or restart hold
    end else begin
      counter <= counter + CNT_W'(1);
    end
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      clk_reg <= 1'b0;
    end else if (restart) begin
      clk_reg <= 1'b0;                          // Start low after restart
    end else if (rise_match) begin
      clk_reg <= 1'b1;                          // Rise on wrap
    end else if (fall_match) begin
      clk_reg <= 1'b0;                          // Fall mid period
    end
  end

  // Bypass counter sits at one so wrap fires every cycle
  assign wrap = rise_match & ~restart;

  // Gated output, clkin passes straight through for code 0
  assign clk_out = out_en & ~restart & (bypass ? clkin : clk_reg);

endmodule

`default_nettype wire

//--- logic/clock_divider_quad.sv
// ##############################
// Quarter-phase link clock divider
// Same ratio as the main divider, lagging by a quarter period
// ##############################
`default_nettype none

module clock_divider_quad
  import clk_cfg_pkg::*;
(
  input  logic      clkin,                      // Reference clock
  input  logic      reset,                      // Async reset
  input  logic      restart,                    // Hold counter at one
  input  logic      out_en,                     // Output gate
  input  div_code_t div_code,                   // Divide code
  output logic      clk_out                     // Quarter-phase clock
);

  logic [CNT_W-1:0] period;                     // One-hot period
  logic [CNT_W-1:0] quarter;                    // Quarter period
  logic [CNT_W-1:0] three_q;                    // Three quarter period
  logic [CNT_W-1:0] counter;                    // Mirrors main counter
  logic             wrap_match;                 // Counter at full period
  logic             rise_match;                 // Counter at quarter
  logic             fall_match;                 // Counter at three quarters
  logic             armed;                      // Main clock has risen once
  logic             clk_reg;                    // Registered quad clock
  logic             quad_ok;                    // Code supports a quarter phase

  // ##############################
  // Match decode
  // ##############################

  assign period     = period_of(div_code);
  assign quarter    = period >> 2;
  assign three_q    = (period >> 1) | (period >> 2);
  assign wrap_match = (counter == period);
  assign rise_match = (counter == quarter);
  assign fall_match = (counter == three_q);
  assign quad_ok    = (div_code >= DIV4);

  // ##############################
  // Counter, arm flag, clock register
  // ##############################

  // Same reload as the main divider so both stay in step
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      counter <= CNT_W'(1);
    end else if (restart || wrap_match) begin
      counter <= CNT_W'(1);
    end else begin
      counter <= counter + CNT_W'(1);
    end
  end

  // First quarter match after restart comes before any main rise
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      armed <= 1'b0;
    end else if (restart) begin
      armed <= 1'b0;
    end else if (wrap_match) begin
      armed <= 1'b1;                            // Main rises on this edge
    end
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      clk_reg <= 1'b0;
    end else if (restart) begin
      clk_reg <= 1'b0;
    end else if (rise_match && armed) begin
      clk_reg <= 1'b1;                          // Quarter after main rise
    end else if (fall_match) begin
      clk_reg <= 1'b0;                          // Quarter after main fall
    end
  end

  // Held low for divide by 1 and 2
  assign clk_out = out_en & ~restart & quad_ok & clk_reg;

endmodule

`default_nettype wire

//--- logic/tx_clk_ctrl.sv
// ##############################
// Transmit clock controller
// Commands, code register, restart sequencing, gating and lock
// ##############################
`default_nettype none

module tx_clk_ctrl
  import clk_cfg_pkg::*;
  import clk_state_pkg::*;
#(
  parameter int RESTART_CYCLES = 2              // Restart hold length, 1 or more
) (
  input  logic      clkin,                      // Reference clock
  input  logic      reset,                      // Async reset
  input  logic      cmd_valid,                  // Command strobe
  input  clk_op_t   cmd_op,                     // Command opcode
  input  logic [3:0] cmd_code,                  // Raw divide code
  input  logic      main_wrap,                  // Main divider wrap pulse
  output div_code_t div_code,                   // Active divide code
  output logic      restart,                    // Divider restart hold
  output logic      out_en,                     // Output gate
  output logic      lock,                       // Dividers running in step
  output logic      cfg_err                     // Bad code pulse
);

  localparam int RC_W = (RESTART_CYCLES > 1) ? $clog2(RESTART_CYCLES) : 1;

  ctrl_state_t     state;                       // Current state
  ctrl_state_t     state_nxt;                   // Next state
  logic [RC_W-1:0] rst_cnt;                     // Restart cycles left minus one
  logic            set_div;                     // SET_DIV seen
  logic            set_ok;                      // SET_DIV with legal code
  logic            set_bad;                     // SET_DIV with code above 7
  logic            do_enable;                   // ENABLE seen
  logic            do_disable;                  // DISABLE seen
  logic            do_restart;                  // Start a new restart sequence

  // ##############################
  // Command decode
  // ##############################

  assign set_div    = cmd_valid && (cmd_op == OP_SET_DIV);
  assign set_ok     = set_div && !cmd_code[3];
  assign set_bad    = set_div && cmd_code[3];
  assign do_enable  = cmd_valid && (cmd_op == OP_ENABLE);
  assign do_disable = cmd_valid && (cmd_op == OP_DISABLE);

  // New code restarts once out of idle, first enable leaves idle
  assign do_restart = (set_ok && (state != ST_IDLE)) ||
                      (do_enable && (state == ST_IDLE));

  // ##############################
  // State machine
  // ##############################

  always_comb begin
    state_nxt = state;
    if (do_restart) begin
      state_nxt = ST_RESTART;                   // Also retriggers during restart
    end else begin
      case (state)
        ST_IDLE:    state_nxt = ST_IDLE;
        ST_RESTART: if (rst_cnt == '0) state_nxt = ST_RUN;
        ST_RUN:     state_nxt = ST_RUN;
        default:    state_nxt = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      state   <= ST_IDLE;
      rst_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (do_restart) begin
        rst_cnt <= RC_W'(RESTART_CYCLES - 1);   // Load hold length
      end else if (state == ST_RESTART && rst_cnt != '0) begin
        rst_cnt <= rst_cnt - RC_W'(1);
      end
    end
  end

  assign restart = (state == ST_RESTART);       // High RESTART_CYCLES cycles

  // ##############################
  // Code register, gate, lock, error
  // ##############################

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      div_code <= DIV1;
      out_en   <= 1'b0;
      lock     <= 1'b0;
      cfg_err  <= 1'b0;
    end else begin
      cfg_err <= set_bad;                       // One-cycle pulse, nothing else moves
      if (set_ok) begin
        div_code <= div_code_t'(cmd_code);
      end
      if (do_enable) begin
        out_en <= 1'b1;
      end else if (do_disable) begin
        out_en <= 1'b0;
      end
      if (do_restart) begin
        lock <= 1'b0;                           // Drop with the restart
      end else if (state == ST_RUN && main_wrap) begin
        lock <= 1'b1;                           // Code 0 wraps every cycle
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/tx_clk_gen.sv
// ##############################
// Transmit link clock generator
// Controller plus main and quarter-phase dividers
// ##############################
`default_nettype none

module tx_clk_gen
  import clk_cfg_pkg::*;
#(
  parameter int RESTART_CYCLES = 2              // Passed to the controller
) (
  input  logic       clkin,                     // Reference clock
  input  logic       reset,                     // Async reset
  input  logic       cmd_valid,                 // Command strobe
  input  clk_op_t    cmd_op,                    // Command opcode
  input  logic [3:0] cmd_code,                  // Raw divide code
  output logic       clk_main,                  // Divided link clock
  output logic       clk_quad,                  // Quarter-phase copy
  output logic       lock,                      // Dividers in step
  output logic       cfg_err                    // Bad code pulse
);

  div_code_t div_code;                          // Shared divide code
  logic      restart;                           // Shared restart hold
  logic      out_en;                            // Shared output gate
  logic      main_wrap;                         // Main period wrap

  tx_clk_ctrl #(
    .RESTART_CYCLES(RESTART_CYCLES)
  ) ctrl0 (
    .clkin    (clkin),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_code (cmd_code),
    .main_wrap(main_wrap),
    .div_code (div_code),
    .restart  (restart),
    .out_en   (out_en),
    .lock     (lock),
    .cfg_err  (cfg_err)
  );

  clock_divider div_main0 (
    .clkin   (clkin),
    .reset   (reset),
    .restart (restart),
    .out_en  (out_en),
    .div_code(div_code),
    .clk_out (clk_main),
    .wrap    (main_wrap)
  );

  clock_divider_quad div_quad0 (
    .clkin   (clkin),
    .reset   (reset),
    .restart (restart),
    .out_en  (out_en),
    .div_code(div_code),
    .clk_out (clk_quad)
  );

endmodule

`default_nettype wire

//--- tb.f
logic/clk_cfg_pkg.sv
logic/clk_state_pkg.sv
logic/clock_divider.sv
logic/clock_divider_quad.sv
logic/tx_clk_ctrl.sv
logic/tx_clk_gen.sv
dv/tx_clk_gen_props.sv
dv/tx_clk_gen_tb.sv
